//--- source/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Address and data widths
`define CACHE_ADDR_W     32
`define CACHE_WORD_W     32

// Set geometry
`define CACHE_INDEX_W    7
`define CACHE_SETS       128
`define CACHE_WAYS       4

// Line layout, four words per line
`define CACHE_LINE_WORDS 4
`define CACHE_OFFSET_W   2

// Address tag above index, word offset and byte offset
`define CACHE_TAG_W      21

// Per-way replacement age
`define CACHE_AGE_W      2

`endif

//--- source/cache_pkg.sv
`default_nettype none

package cache_pkg;

`include "cache_config.svh"

    // Address parts
    typedef logic [`CACHE_TAG_W-1:0]    tag_t;
    typedef logic [`CACHE_INDEX_W-1:0]  index_t;
    typedef logic [`CACHE_OFFSET_W-1:0] offset_t;

    typedef logic [$clog2(`CACHE_WAYS)-1:0] way_t;
    typedef logic [`CACHE_AGE_W-1:0]        age_t;
    typedef logic [`CACHE_WORD_W-1:0]       word_t;

    // One way of a tag RAM entry
    typedef struct packed {
        logic valid;
        tag_t tag;
        age_t age;
    } way_entry_t;

    // Whole set, way 0 in the low bits
    typedef struct packed {
        way_entry_t [`CACHE_WAYS-1:0] way;
    } set_entry_t;

    typedef enum logic [1:0] {
        LOAD_WORD,
        LOAD_BYTE,
        LOAD_BYTE_U
    } load_kind_t;

    typedef enum logic [2:0] {
        ST_SWEEP,
        ST_IDLE,
        ST_LOOKUP,
        ST_HIT,
        ST_FILL_FIRST,
        ST_FILL_REST
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- source/cache_ram.sv
`timescale 1ns/100ps
`default_nettype none

// Single-port RAM with registered read
module cache_ram
#(
    parameter type entry_t = logic [31:0],
    parameter int  depth   = 128
)
(
    input  wire logic                     clk,
    input  wire logic [$clog2(depth)-1:0] addr,
    input  wire logic                     we,
    input  wire entry_t                   wdata,
    output entry_t                        rdata
);

    entry_t mem [depth];

    // Read only when not writing, output holds during a write
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[addr] <= wdata;
        end
        else
        begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

//--- source/set_lookup.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_config.svh"

module set_lookup
    import cache_pkg::*;
(
    input  wire set_entry_t entry,
    input  wire tag_t       tag,
    input  wire way_t       fill_way,
    input  wire logic       use_fill_way,
    output logic            hit,
    output way_t            hit_way,
    output way_t            victim_way,
    output set_entry_t      updated_entry
);

    way_t acc_way;

    // Tag compare, lowest matching way wins
    always_comb
    begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++)
        begin
            if (!hit && entry.way[w].valid && entry.way[w].tag == tag)
            begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    ////////////////////////////////
    // Victim choice
    ////////////////////////////////

    always_comb
    begin
        logic found_invalid;
        age_t max_age;

        found_invalid = 1'b0;
        max_age       = entry.way[0].age;
        victim_way    = '0;
        for (int w = 1; w < `CACHE_WAYS; w++)
        begin
            // Strictly greater keeps the lowest way on a tie
            if (entry.way[w].age > max_age)
            begin
                max_age    = entry.way[w].age;
                victim_way = way_t'(w);
            end
        end
        // First invalid way overrides the age pick
        for (int w = 0; w < `CACHE_WAYS; w++)
        begin
            if (!found_invalid && !entry.way[w].valid)
            begin
                found_invalid = 1'b1;
                victim_way    = way_t'(w);
            end
        end
    end

    ////////////////////////////////
    // Age update
    ////////////////////////////////

    assign acc_way = use_fill_way ? fill_way : hit_way;

    always_comb
    begin
        updated_entry = entry;
        for (int w = 0; w < `CACHE_WAYS; w++)
        begin
            if (way_t'(w) == acc_way)
            begin
                updated_entry.way[w].valid = 1'b1;
                updated_entry.way[w].tag   = tag;
                updated_entry.way[w].age   = '0;
            end
            else if (entry.way[w].age != '1)
            begin
                updated_entry.way[w].age = entry.way[w].age + age_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

//--- source/cache_control.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_config.svh"

module cache_control
    import cache_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     rst,

    input  wire logic                     cpu_req,
    input  wire logic                     cpu_write,
    input  wire logic [`CACHE_ADDR_W-1:0] cpu_addr,
    input  wire word_t                    cpu_wdata,

    input  wire logic                     mem_ack,
    input  wire word_t                    mem_rdata,

    input  wire logic                     hit,
    input  wire way_t                     hit_way,
    input  wire way_t                     victim_way,
    input  wire set_entry_t               updated_entry,

    output index_t                        tag_addr,
    output logic                          tag_we,
    output set_entry_t                    tag_wdata,

    output logic [`CACHE_INDEX_W+$clog2(`CACHE_WAYS)+`CACHE_OFFSET_W-1:0] data_addr,
    output logic                          data_we,
    output word_t                         data_wdata,

    output way_t                          fill_way,
    output logic                          use_fill_way,

    output logic                          cpu_ack,
    output logic                          fill_select,
    output logic                          mem_req,
    output logic [`CACHE_ADDR_W-1:0]      mem_addr
);

    localparam int OFFSET_LSB = 2;
    localparam int INDEX_LSB  = OFFSET_LSB + `CACHE_OFFSET_W;
    localparam int TAG_LSB    = INDEX_LSB + `CACHE_INDEX_W;

    ctrl_state_t              state;
    ctrl_state_t              state_next;
    index_t                   sweep_cnt;
    offset_t                  fill_cnt;
    logic [`CACHE_ADDR_W-1:0] req_addr;

    tag_t    req_tag;
    index_t  req_index;
    offset_t req_offset;
    logic    filling;

    assign req_tag    = req_addr[TAG_LSB +: `CACHE_TAG_W];
    assign req_index  = req_addr[INDEX_LSB +: `CACHE_INDEX_W];
    assign req_offset = req_addr[OFFSET_LSB +: `CACHE_OFFSET_W];
    assign filling    = (state == ST_FILL_FIRST) || (state == ST_FILL_REST);

    ////////////////////////////////
    // State and sweep counter
    ////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= ST_SWEEP;
            sweep_cnt <= '0;
        end
        else
        begin
            state <= state_next;
            if (state == ST_SWEEP)
            begin
                sweep_cnt <= sweep_cnt + index_t'(1);
            end
        end
    end

    always_comb
    begin
        state_next = state;
        case (state)
            ST_SWEEP:
                if (sweep_cnt == index_t'(`CACHE_SETS - 1))
                    state_next = ST_IDLE;
            ST_IDLE:
                if (cpu_req)
                    state_next = ST_LOOKUP;
            ST_LOOKUP:
                state_next = hit ? ST_HIT : ST_FILL_FIRST;
            ST_HIT:
                state_next = ST_IDLE;
            ST_FILL_FIRST:
                if (mem_ack)
                    state_next = ST_FILL_REST;
            ST_FILL_REST:
                // Line done once the counter wraps back to the critical word
                if (mem_ack && fill_cnt + offset_t'(1) == req_offset)
                    state_next = ST_IDLE;
            default:
                state_next = ST_SWEEP;
        endcase
    end

    // Request address, refill way and refill word counter
    always_ff @(posedge clk)
    begin
        if (state == ST_IDLE && cpu_req)
        begin
            req_addr <= cpu_addr;
        end
        if (state == ST_LOOKUP && !hit)
        begin
            fill_way <= victim_way;
            fill_cnt <= req_offset;
        end
        else if (filling && mem_ack)
        begin
            fill_cnt <= fill_cnt + offset_t'(1);
        end
    end

    ////////////////////////////////
    // RAM control
    ////////////////////////////////

    always_comb
    begin
        case (state)
            ST_SWEEP: tag_addr = sweep_cnt;
            ST_IDLE:  tag_addr = cpu_addr[INDEX_LSB +: `CACHE_INDEX_W];
            default:  tag_addr = req_index;
        endcase
    end

    assign tag_we    = (state == ST_SWEEP) || (state == ST_HIT)
                     || (state == ST_FILL_FIRST && mem_ack);
    assign tag_wdata = (state == ST_SWEEP) ? '0 : updated_entry;

    assign data_addr = filling ? {req_index, fill_way, fill_cnt}
                               : {req_index, hit_way, req_offset};
    assign data_we   = (state == ST_HIT && cpu_write) || (filling && mem_ack);

    // Store miss puts the store word in place of the critical word
    assign data_wdata = (state == ST_HIT || (state == ST_FILL_FIRST && cpu_write))
                      ? cpu_wdata : mem_rdata;

    ////////////////////////////////
    // CPU and memory handshake
    ////////////////////////////////

    assign use_fill_way = (state == ST_FILL_FIRST);
    assign fill_select  = (state == ST_FILL_FIRST);
    assign cpu_ack      = (state == ST_HIT) || (state == ST_FILL_FIRST && mem_ack);
    assign mem_req      = filling;
    assign mem_addr     = {req_tag, req_index, fill_cnt, 2'b00};

endmodule

`default_nettype wire

//--- source/load_format.sv
`timescale 1ns/100ps
`default_nettype none

module load_format
    import cache_pkg::*;
(
    input  wire word_t      ram_word,
    input  wire word_t      mem_word,
    input  wire logic       fill_select,
    input  wire logic [1:0] byte_sel,
    input  wire logic       cpu_lb,
    input  wire logic       cpu_lbu,
    output word_t           rdata
);

    word_t      word;
    logic [7:0] sel_byte;
    load_kind_t kind;

    // Critical word comes straight from memory during a fill
    assign word = fill_select ? mem_word : ram_word;

    assign sel_byte = word[{byte_sel, 3'b000} +: 8];

    always_comb
    begin
        if (cpu_lb)
            kind = LOAD_BYTE;
        else if (cpu_lbu)
            kind = LOAD_BYTE_U;
        else
            kind = LOAD_WORD;
    end

    always_comb
    begin
        case (kind)
            LOAD_BYTE:   rdata = {{($bits(word_t) - 8){sel_byte[7]}}, sel_byte};
            LOAD_BYTE_U: rdata = {{($bits(word_t) - 8){1'b0}}, sel_byte};
            default:     rdata = word;
        endcase
    end

endmodule

`default_nettype wire

//--- source/cache_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_config.svh"

module cache_top
    import cache_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     rst,

    input  wire logic                     cpu_req,
    input  wire logic [`CACHE_ADDR_W-1:0] cpu_addr,
    input  wire word_t                    cpu_wdata,
    input  wire logic                     cpu_write,
    input  wire logic                     cpu_lb,
    input  wire logic                     cpu_lbu,
    output logic                          cpu_ack,
    output word_t                         cpu_rdata,

    output logic                          mem_req,
    output logic [`CACHE_ADDR_W-1:0]      mem_addr,
    input  wire logic                     mem_ack,
    input  wire word_t                    mem_rdata
);

    localparam int DATA_DEPTH = `CACHE_SETS * `CACHE_WAYS * `CACHE_LINE_WORDS;

    index_t                          tag_addr;
    logic                            tag_we;
    set_entry_t                      tag_wdata;
    set_entry_t                      tag_rdata;

    logic [$clog2(DATA_DEPTH)-1:0]   data_addr;
    logic                            data_we;
    word_t                           data_wdata;
    word_t                           data_rdata;

    logic       hit;
    way_t       hit_way;
    way_t       victim_way;
    set_entry_t updated_entry;
    way_t       fill_way;
    logic       use_fill_way;
    logic       fill_select;

    cache_ram #(.entry_t(set_entry_t), .depth(`CACHE_SETS)) tag_ram (
        .clk   (clk),
        .addr  (tag_addr),
        .we    (tag_we),
        .wdata (tag_wdata),
        .rdata (tag_rdata)
    );

    cache_ram #(.entry_t(word_t), .depth(DATA_DEPTH)) data_ram (
        .clk   (clk),
        .addr  (data_addr),
        .we    (data_we),
        .wdata (data_wdata),
        .rdata (data_rdata)
    );

    // Decode stage
    set_lookup u_set_lookup (
        .entry         (tag_rdata),
        .tag           (cpu_addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W]),
        .fill_way      (fill_way),
        .use_fill_way  (use_fill_way),
        .hit           (hit),
        .hit_way       (hit_way),
        .victim_way    (victim_way),
        .updated_entry (updated_entry)
    );

    // Execute stage
    cache_control u_cache_control (
        .clk           (clk),
        .rst           (rst),
        .cpu_req       (cpu_req),
        .cpu_write     (cpu_write),
        .cpu_addr      (cpu_addr),
        .cpu_wdata     (cpu_wdata),
        .mem_ack       (mem_ack),
        .mem_rdata     (mem_rdata),
        .hit           (hit),
        .hit_way       (hit_way),
        .victim_way    (victim_way),
        .updated_entry (updated_entry),
        .tag_addr      (tag_addr),
        .tag_we        (tag_we),
        .tag_wdata     (tag_wdata),
        .data_addr     (data_addr),
        .data_we       (data_we),
        .data_wdata    (data_wdata),
        .fill_way      (fill_way),
        .use_fill_way  (use_fill_way),
        .cpu_ack       (cpu_ack),
        .fill_select   (fill_select),
        .mem_req       (mem_req),
        .mem_addr      (mem_addr)
    );

    // Result stage
    load_format u_load_format (
        .ram_word    (data_rdata),
        .mem_word    (mem_rdata),
        .fill_select (fill_select),
        .byte_sel    (cpu_addr[1:0]),
        .cpu_lb      (cpu_lb),
        .cpu_lbu     (cpu_lbu),
        .rdata       (cpu_rdata)
    );

endmodule

`default_nettype wire

//--- testbench/cache_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_config.svh"

module cache_checker
(
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     cpu_req,
    input  wire logic [`CACHE_ADDR_W-1:0] cpu_addr,
    input  wire logic                     cpu_write,
    input  wire logic                     cpu_ack,
    input  wire logic [`CACHE_WORD_W-1:0] cpu_rdata,
    input  wire logic                     mem_req,
    input  wire logic [`CACHE_ADDR_W-1:0] mem_addr,
    input  wire logic                     mem_ack,
    input  wire logic [8*16-1:0]          test_name,
    input  wire logic [`CACHE_WORD_W-1:0] exp_rdata,
    input  wire logic                     exp_miss,
    output int                            error_count
);

    // Cycles from request in idle to hit ack, not counting the ack cycle
    localparam int HIT_WAIT = 2;

    int                       check_count;
    int                       ack_count;
    int                       sweep_left;
    int                       refill_left;
    int                       req_cycles;
    logic                     miss_seen;
    logic                     mem_req_q;
    logic [`CACHE_ADDR_W-1:0] line_base;
    logic [1:0]               next_off;

    initial
    begin
        error_count = 0;
        check_count = 0;
        ack_count   = 0;
        sweep_left  = `CACHE_SETS;
        refill_left = 0;
        req_cycles  = 0;
        miss_seen   = 1'b0;
        mem_req_q   = 1'b0;
        line_base   = '0;
        next_off    = '0;
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual)
        begin
            $display("[FAIL] %0s %0s expected %0h actual %0h", test_name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic print_summary(input int run_errors);
        $display("Summary: %0d requests, %0d checks, %0d check errors, %0d run errors",
                 ack_count, check_count, error_count, run_errors);
    endtask

    always @(posedge clk)
    begin : watch
        logic                     busy;
        logic                     in_sweep;
        logic                     miss_now;
        logic [`CACHE_ADDR_W-1:0] exp_addr;

        busy     = (refill_left != 0);
        in_sweep = (sweep_left > 0);
        miss_now = miss_seen;
        if (rst)
        begin
            sweep_left  = `CACHE_SETS;
            refill_left = 0;
            req_cycles  = 0;
            miss_seen   = 1'b0;
            mem_req_q   = 1'b0;
        end
        else
        begin
            if (in_sweep)
            begin
                if (cpu_ack || mem_req)
                begin
                    $display("Error: cpu_ack or mem_req was high during the reset sweep");
                    error_count++;
                end
                sweep_left--;
            end

            // A miss raises mem_req once, the refill then holds it high
            if (mem_req && !mem_req_q)
                miss_now = 1'b1;
            mem_req_q = mem_req;

            // Refill starts at the requested word and wraps around the line
            if (mem_req && mem_ack)
            begin
                if (refill_left == 0)
                begin
                    exp_addr    = {cpu_addr[`CACHE_ADDR_W-1:2], 2'b00};
                    line_base   = {cpu_addr[`CACHE_ADDR_W-1:4], 4'b0000};
                    next_off    = cpu_addr[3:2] + 2'd1;
                    refill_left = `CACHE_LINE_WORDS - 1;
                end
                else
                begin
                    exp_addr = {line_base[`CACHE_ADDR_W-1:4], next_off, 2'b00};
                    next_off = next_off + 2'd1;
                    refill_left--;
                end
                check_value("refill address", exp_addr, mem_addr);
            end

            if (cpu_ack)
            begin
                ack_count++;
                check_value("miss flag", 32'(exp_miss), 32'(miss_now));
                if (!cpu_write)
                    check_value("read data", exp_rdata, cpu_rdata);
                if (!exp_miss && !miss_now)
                    check_value("hit latency", 32'(HIT_WAIT), 32'(req_cycles));
                req_cycles = 0;
                miss_seen  = 1'b0;
            end
            else
            begin
                miss_seen = miss_now;
                if (cpu_req && !busy && !in_sweep)
                    req_cycles++;
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_cache.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_config.svh"

module tb_cache;

    localparam int                     ACK_TIMEOUT  = 200;
    localparam int                     IDLE_TIMEOUT = 100;
    localparam int                     QUIET_NEEDED = 8;
    localparam logic [`CACHE_ADDR_W-1:0] MODEL_XOR  = 32'ha5a50000;
    localparam logic [8*8-1:0]         OP_SW        = "sw";
    localparam logic [8*8-1:0]         OP_LB        = "lb";
    localparam logic [8*8-1:0]         OP_LBU       = "lbu";

    logic                     clk;
    logic                     rst;
    logic                     cpu_req;
    logic [`CACHE_ADDR_W-1:0] cpu_addr;
    logic [`CACHE_WORD_W-1:0] cpu_wdata;
    logic                     cpu_write;
    logic                     cpu_lb;
    logic                     cpu_lbu;
    logic                     cpu_ack;
    logic [`CACHE_WORD_W-1:0] cpu_rdata;
    logic                     mem_req;
    logic [`CACHE_ADDR_W-1:0] mem_addr;
    logic                     mem_ack;
    logic [`CACHE_WORD_W-1:0] mem_rdata;

    // Expected values handed to the checker
    logic [8*16-1:0]          test_name;
    logic [`CACHE_WORD_W-1:0] exp_rdata;
    logic                     exp_miss;
    int                       error_count;
    int                       run_errors;

    integer                   seed;
    int                       mem_delay;

    // One parsed line of the test file
    integer                   fd;
    integer                   fields;
    logic [8*128-1:0]         line_buf;
    logic [8*16-1:0]          f_name;
    logic [8*8-1:0]           f_op;
    logic [`CACHE_ADDR_W-1:0] f_addr;
    logic [`CACHE_WORD_W-1:0] f_wdata;
    logic [`CACHE_WORD_W-1:0] f_exp;
    integer                   f_miss;

    logic                     got_ack;
    int                       wait_cycles;
    int                       quiet_cycles;

    always #2 clk = ~clk;

    cache_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_req),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_write (cpu_write),
        .cpu_lb    (cpu_lb),
        .cpu_lbu   (cpu_lbu),
        .cpu_ack   (cpu_ack),
        .cpu_rdata (cpu_rdata),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    cache_checker checker0 (
        .clk         (clk),
        .rst         (rst),
        .cpu_req     (cpu_req),
        .cpu_addr    (cpu_addr),
        .cpu_write   (cpu_write),
        .cpu_ack     (cpu_ack),
        .cpu_rdata   (cpu_rdata),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_ack     (mem_ack),
        .test_name   (test_name),
        .exp_rdata   (exp_rdata),
        .exp_miss    (exp_miss),
        .error_count (error_count)
    );

    //////////////////////////////
    // Memory model
    //////////////////////////////

    // Answers each request after 1 to 4 cycles, word is address xor constant
    always
    begin
        @(negedge clk);
        mem_ack = 1'b0;
        if (mem_req && !rst)
        begin
            mem_delay = 1 + ($unsigned($random(seed)) % 4);
            repeat (mem_delay) @(negedge clk);
            mem_rdata = mem_addr ^ MODEL_XOR;
            mem_ack   = 1'b1;
        end
    end

    //////////////////////////////
    // CPU stimulus
    //////////////////////////////

    task automatic run_request();
        @(negedge clk);
        test_name = f_name;
        exp_rdata = f_exp;
        exp_miss  = (f_miss != 0);
        cpu_addr  = f_addr;
        cpu_wdata = f_wdata;
        cpu_write = (f_op == OP_SW);
        cpu_lb    = (f_op == OP_LB);
        cpu_lbu   = (f_op == OP_LBU);
        cpu_req   = 1'b1;
        got_ack     = 1'b0;
        wait_cycles = 0;
        while (!got_ack && wait_cycles < ACK_TIMEOUT)
        begin
            @(posedge clk);
            wait_cycles++;
            if (cpu_ack)
                got_ack = 1'b1;
        end
        if (!got_ack)
        begin
            $display("Timeout: test %0s got no cpu_ack within %0d cycles", f_name, ACK_TIMEOUT);
            run_errors++;
        end
    endtask

    initial
    begin
        seed       = 29175;
        clk        = 1'b0;
        rst        = 1'b1;
        cpu_req    = 1'b0;
        cpu_addr   = '0;
        cpu_wdata  = '0;
        cpu_write  = 1'b0;
        cpu_lb     = 1'b0;
        cpu_lbu    = 1'b0;
        mem_ack    = 1'b0;
        mem_rdata  = '0;
        test_name  = '0;
        exp_rdata  = '0;
        exp_miss   = 1'b0;
        run_errors = 0;

        repeat (16) @(negedge clk);
        rst = 1'b0;

        // First request goes out during the sweep and has to wait
        fd = $fopen("testbench/cache_tests.dat", "r");
        if (fd == 0)
        begin
            $display("Could not open the test file testbench/cache_tests.dat");
            run_errors++;
        end
        else
        begin
            while (run_errors == 0 && !$feof(fd))
            begin
                line_buf = '0;
                if ($fgets(line_buf, fd) != 0)
                begin
                    fields = $sscanf(line_buf, "%s %s %h %h %h %d",
                                     f_name, f_op, f_addr, f_wdata, f_exp, f_miss);
                    if (fields == 6)
                        run_request();
                end
            end
            $fclose(fd);
        end

        @(negedge clk);
        cpu_req   = 1'b0;
        cpu_write = 1'b0;
        cpu_lb    = 1'b0;
        cpu_lbu   = 1'b0;

        // Background refill of the last miss has to drain
        quiet_cycles = 0;
        wait_cycles  = 0;
        while (quiet_cycles < QUIET_NEEDED && wait_cycles < IDLE_TIMEOUT)
        begin
            @(posedge clk);
            wait_cycles++;
            if (mem_req)
                quiet_cycles = 0;
            else
                quiet_cycles++;
        end
        if (quiet_cycles < QUIET_NEEDED)
        begin
            $display("Timeout: memory requests did not stop after the last test");
            run_errors++;
        end

        checker0.print_summary(run_errors);
        if (run_errors == 0 && error_count == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/cache_tests.dat
# Columns: name, op (lw lb lbu sw), byte address, store data, expected load data, miss flag
# Hex values except the miss flag; a memory word is its word address xor a5a50000
first_lw      lw  00001234 00000000 a5a51234 1
hit_w0        lw  00001230 00000000 a5a51230 0
hit_w2        lw  00001238 00000000 a5a51238 0
hit_w3        lw  0000123c 00000000 a5a5123c 0
hit_w1        lw  00001234 00000000 a5a51234 0
lb_miss_b0    lb  00003080 00000000 ffffff80 1
lbu_hit_b1    lbu 00003081 00000000 00000030 0
lb_hit_b2     lb  00003082 00000000 ffffffa5 0
lbu_hit_b3    lbu 00003083 00000000 000000a5 0
lbu_hit_b0    lbu 00003080 00000000 00000080 0
lb_hit_b1     lb  00003081 00000000 00000030 0
lbu_hit_b2    lbu 00003082 00000000 000000a5 0
lb_hit_b3     lb  00003083 00000000 ffffffa5 0
lbu_miss_b3   lbu 000040c3 00000000 000000a5 1
lbu_miss_b0   lbu 000050f0 00000000 000000f0 1
lb_miss_b1    lb  000060e1 00000000 00000060 1
lb_miss_b2    lb  00007092 00000000 ffffffa5 1
lb_miss_b3    lb  0000a0b7 00000000 ffffffa5 1
lbu_miss_b1   lbu 0000c0d9 00000000 000000c0 1
lbu_miss_b2   lbu 0000e03a 00000000 000000a5 1
sw_hit        sw  00001238 deadbeef 00000000 0
lw_after_swh  lw  00001238 00000000 deadbeef 0
lw_swh_nbr    lw  0000123c 00000000 a5a5123c 0
sw_miss       sw  00008014 12345678 00000000 1
lw_after_swm  lw  00008014 00000000 12345678 0
lw_swm_nbr    lw  00008010 00000000 a5a58010 0
lb_swm_b3     lb  00008017 00000000 00000012 0
rep_a_fill    lw  00000a00 00000000 a5a50a00 1
rep_a_store   sw  00000a04 cafef00d 00000000 0
rep_a_load    lw  00000a04 00000000 cafef00d 0
rep_b_fill    lw  00001200 00000000 a5a51200 1
rep_c_fill    lw  00001a00 00000000 a5a51a00 1
rep_d_fill    lw  00002200 00000000 a5a52200 1
rep_e_evict_a lw  00002a08 00000000 a5a52a08 1
rep_a_again   lw  00000a04 00000000 a5a50a04 1
rep_e_hit     lw  00002a00 00000000 a5a52a00 0
rep_b_evicted lw  00001200 00000000 a5a51200 1
rep_d_hit     lw  00002200 00000000 a5a52200 0
rep_c_evicted lw  00001a00 00000000 a5a51a00 1
rep_b_hit     lw  00001204 00000000 a5a51204 0
rep_a_gone    lw  00000a00 00000000 a5a50a00 1

//--- vlog.f
+incdir+source
source/cache_pkg.sv
source/cache_ram.sv
source/set_lookup.sv
source/cache_control.sv
source/load_format.sv
source/cache_top.sv
testbench/cache_checker.sv
testbench/tb_cache.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_cache

verilator --binary --timing -f vlog.f --top-module tb_cache -Mdir obj_dir -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Verdict comes from the log
if grep -q "Test failed" "$LOG"; then
    exit 1
fi
exit 0
